//--- hw/ldq_entry_array.sv
`timescale 1ns/10ps
`include "ldq_macros.svh"

module ldq_entry_array (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              i_alloc_en,
   input  logic [`LDQ_LANES-1:0]             i_alloc_vld,
   input  logic [`LDQ_LANES*`LDQ_TAG_W-1:0]  i_alloc_tags,
   input  ldq_pkg::ldq_ptr_t                 i_tail,
   input  ldq_pkg::ldq_ptr_t                 i_head,
   input  logic                              i_upd_vld,
   input  ldq_pkg::ldq_tag_t                 i_upd_tag,
   input  ldq_pkg::ldq_addr_t                i_upd_addr,
   input  ldq_pkg::ldq_preg_t                i_upd_preg,
   input  logic [`LDQ_DEPTH-1:0]             i_commit_mask,
   input  logic [`LDQ_DEPTH-1:0]             i_flush_mask,
   input  ldq_pkg::ldq_ptr_t                 i_cur_ptr,
   input  logic                              i_finish,
   input  logic                              i_busy,
   output logic [`LDQ_DEPTH-1:0]             o_bid,
   output logic                              o_head_vld,
   output ldq_pkg::ldq_addr_t                o_cur_addr,
   output ldq_pkg::ldq_preg_t                o_cur_preg,
   output ldq_pkg::ldq_tag_t                 o_cur_tag
);

   localparam logic [`LDQ_PTR_W:0] DEPTH_W = `LDQ_DEPTH;

   // status bits per entry
   logic [`LDQ_DEPTH-1:0] vld_q, rdy_q, done_q;

   // payload fields
   ldq_pkg::ldq_tag_t     tag_q  [`LDQ_DEPTH];
   ldq_pkg::ldq_addr_t    addr_q [`LDQ_DEPTH];
   ldq_pkg::ldq_preg_t    preg_q [`LDQ_DEPTH];

   logic [`LDQ_DEPTH-1:0] ins_mask, upd_hit, cur_sel;
   ldq_pkg::ldq_tag_t     ins_tag   [`LDQ_DEPTH];
   ldq_pkg::ldq_ptr_t     lane_slot [`LDQ_LANES];

   // lane k lands at tail+k
   always_comb begin
      logic [`LDQ_PTR_W:0] sum;
      for (int k = 0; k < `LDQ_LANES; k++) begin
         sum = {1'b0, i_tail} + (`LDQ_PTR_W+1)'(k);
         if (sum >= DEPTH_W)
            sum = sum - DEPTH_W;
         lane_slot[k] = sum[`LDQ_PTR_W-1:0];
      end
   end

   always_comb begin
      for (int i = 0; i < `LDQ_DEPTH; i++) begin
         ins_mask[i] = 1'b0;
         ins_tag[i]  = '0;
         for (int k = 0; k < `LDQ_LANES; k++) begin
            if (i_alloc_en && i_alloc_vld[k] && (lane_slot[k] == i)) begin
               ins_mask[i] = 1'b1;
               ins_tag[i]  = i_alloc_tags[k*`LDQ_TAG_W +: `LDQ_TAG_W];
            end
         end
         // address unit result, matched by tag
         upd_hit[i] = i_upd_vld & vld_q[i] & (tag_q[i] == i_upd_tag);
         cur_sel[i] = (i_cur_ptr == i);
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         vld_q  <= '0;
         rdy_q  <= '0;
         done_q <= '0;
      end else begin
         for (int i = 0; i < `LDQ_DEPTH; i++) begin
            if (i_flush_mask[i] || i_commit_mask[i]) begin  // squash first, then retire
               vld_q[i]  <= 1'b0;
               rdy_q[i]  <= 1'b0;
               done_q[i] <= 1'b0;
            end else if (ins_mask[i]) begin
               vld_q[i]  <= 1'b1;
               rdy_q[i]  <= 1'b0;
               done_q[i] <= 1'b0;
            end else begin
               if (upd_hit[i])
                  rdy_q[i] <= 1'b1;
               if (i_finish && cur_sel[i])
                  done_q[i] <= 1'b1;  // written back, never bids again
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `LDQ_DEPTH; i++) begin
         if (ins_mask[i])
            tag_q[i] <= ins_tag[i];
         if (upd_hit[i]) begin
            addr_q[i] <= i_upd_addr;
            preg_q[i] <= i_upd_preg;
         end
      end
   end

   // ready loads not yet done, held off while a load is in flight
   assign o_bid      = vld_q & rdy_q & ~done_q & {`LDQ_DEPTH{~i_busy}};
   assign o_head_vld = vld_q[i_head];

   assign o_cur_addr = addr_q[i_cur_ptr];
   assign o_cur_preg = preg_q[i_cur_ptr];
   assign o_cur_tag  = tag_q[i_cur_ptr];

endmodule

//--- hw/ldq_issue_ctrl.sv
`timescale 1ns/10ps

module ldq_issue_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               i_ld_rdy,
   input  logic               i_flsh,
   input  logic               i_ld_grnt,
   input  logic               i_done,
   input  ldq_pkg::ldq_data_t i_data_ca,
   input  logic               i_fwd_rdy,
   input  logic               i_fwd,
   input  ldq_pkg::ldq_data_t i_data_sq,
   output logic               o_ld_req,
   output logic               o_busy,
   output logic               o_finish,
   output logic               o_ld_wb,
   output ldq_pkg::ldq_data_t o_ld_data
);

   ldq_pkg::ldq_state_e state, nxt_state;

   logic                fwd_q;       // store queue supplies the data
   ldq_pkg::ldq_data_t  data_ca_q;
   ldq_pkg::ldq_data_t  data_sq_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         state <= ldq_pkg::IDLE;
      else
         state <= nxt_state;
   end

   always_comb begin
      nxt_state = state;
      if (i_flsh) begin
         nxt_state = ldq_pkg::IDLE;  // flush drops whatever is in flight
      end else begin
         case (state)
            ldq_pkg::IDLE: begin
               if (i_ld_rdy)
                  nxt_state = ldq_pkg::WAIT;
            end
            ldq_pkg::WAIT: begin
               if (i_ld_grnt)
                  nxt_state = ldq_pkg::ISSUED;
            end
            ldq_pkg::ISSUED: begin
               if (i_done && i_fwd_rdy)
                  nxt_state = ldq_pkg::BOTH_RDY;
               else if (i_done)
                  nxt_state = ldq_pkg::MEM_RDY;
               else if (i_fwd_rdy)
                  nxt_state = ldq_pkg::FWD_RDY;
            end
            ldq_pkg::MEM_RDY: begin
               if (i_fwd_rdy)
                  nxt_state = ldq_pkg::WRITEBACK;
            end
            ldq_pkg::FWD_RDY: begin
               if (i_done)
                  nxt_state = ldq_pkg::WRITEBACK;
            end
            ldq_pkg::BOTH_RDY: begin
               nxt_state = ldq_pkg::WRITEBACK;
            end
            ldq_pkg::WRITEBACK: begin
               if (i_ld_rdy)
                  nxt_state = ldq_pkg::WAIT;
               else
                  nxt_state = ldq_pkg::IDLE;
            end
            default: begin
               nxt_state = ldq_pkg::IDLE;
            end
         endcase
      end
   end

   // return data is captured on its own strobe, in whichever order it comes
   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         fwd_q <= 1'b0;
      else if (i_fwd_rdy)
         fwd_q <= i_fwd;
   end

   always_ff @(posedge clk) begin
      if (i_done)
         data_ca_q <= i_data_ca;
      if (i_fwd_rdy)
         data_sq_q <= i_data_sq;
   end

   assign o_ld_req  = (state == ldq_pkg::WAIT);  // held until granted
   assign o_busy    = (state != ldq_pkg::IDLE);
   assign o_ld_wb   = (state == ldq_pkg::WRITEBACK) & ~i_flsh;
   assign o_finish  = o_ld_wb;  // marks the entry done at the same edge
   assign o_ld_data = fwd_q ? data_sq_q : data_ca_q;

endmodule

//--- hw/ldq_oldest_select.sv
`timescale 1ns/10ps
`include "ldq_macros.svh"

module ldq_oldest_select (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`LDQ_DEPTH-1:0] i_bid,
   input  ldq_pkg::ldq_ptr_t     i_head,
   input  logic                  i_busy,
   output ldq_pkg::ldq_ptr_t     o_cur_ptr,
   output logic                  o_ld_rdy
);

   localparam logic [`LDQ_PTR_W:0] DEPTH_W = `LDQ_DEPTH;

   logic [`LDQ_DEPTH-1:0] rot_bid;   // bit 0 is the head slot
   ldq_pkg::ldq_ptr_t     offset, pre_cur, cur_ptr;

   always_comb begin
      logic [`LDQ_PTR_W:0] idx;
      logic [`LDQ_PTR_W:0] sum;
      for (int j = 0; j < `LDQ_DEPTH; j++) begin
         idx = {1'b0, i_head} + (`LDQ_PTR_W+1)'(j);
         if (idx >= DEPTH_W)
            idx = idx - DEPTH_W;
         rot_bid[j] = i_bid[idx[`LDQ_PTR_W-1:0]];
      end

      // lowest set bit is the oldest bidder
      offset = '0;
      for (int j = `LDQ_DEPTH-1; j >= 0; j--) begin
         if (rot_bid[j])
            offset = ldq_pkg::ldq_ptr_t'(j);
      end

      sum = {1'b0, i_head} + {1'b0, offset};
      if (sum >= DEPTH_W)
         sum = sum - DEPTH_W;  // back to an absolute slot
      pre_cur = sum[`LDQ_PTR_W-1:0];
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         cur_ptr <= '0;
      else if (!i_busy)
         cur_ptr <= pre_cur;  // frozen for the load in flight
   end

   assign o_cur_ptr = cur_ptr;
   assign o_ld_rdy  = |i_bid;

endmodule

//--- hw/ldq_pkg.sv
`include "ldq_macros.svh"

package ldq_pkg;

   typedef logic [`LDQ_PTR_W-1:0]  ldq_ptr_t;   // slot index into the circular buffer
   typedef logic [`LDQ_TAG_W-1:0]  ldq_tag_t;
   typedef logic [`LDQ_PREG_W-1:0] ldq_preg_t;  // physical destination register
   typedef logic [`LDQ_ADDR_W-1:0] ldq_addr_t;
   typedef logic [`LDQ_DATA_W-1:0] ldq_data_t;

   // issue FSM, one load in flight at a time
   typedef enum logic [2:0] {
      IDLE      = 3'd0,  // nothing to issue
      WAIT      = 3'd1,  // requesting the memory port
      ISSUED    = 3'd2,  // granted, waiting on cache and store queue
      MEM_RDY   = 3'd3,  // cache data in, store queue pending
      FWD_RDY   = 3'd4,  // store queue result in, cache pending
      BOTH_RDY  = 3'd5,
      WRITEBACK = 3'd6   // one cycle of writeback
   } ldq_state_e;

endpackage

//--- hw/ldq_ptr_ctrl.sv
`timescale 1ns/10ps
`include "ldq_macros.svh"

module ldq_ptr_ctrl (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`LDQ_LANES-1:0]   i_alloc_vld,
   input  logic                    i_flsh,
   input  ldq_pkg::ldq_ptr_t       i_flush_ptr,
   input  ldq_pkg::ldq_ptr_t       i_cmmt_ptr,
   input  logic                    i_head_vld,
   output ldq_pkg::ldq_ptr_t       o_head,
   output ldq_pkg::ldq_ptr_t       o_tail,
   output logic                    o_alloc_en,
   output logic [`LDQ_DEPTH-1:0]   o_commit_mask,
   output logic [`LDQ_DEPTH-1:0]   o_flush_mask,
   output logic                    o_stll
);

   localparam logic [`LDQ_PTR_W:0] DEPTH_W   = `LDQ_DEPTH;
   localparam logic [`LDQ_PTR_W:0] STALL_LVL = `LDQ_DEPTH - `LDQ_LANES;

   ldq_pkg::ldq_ptr_t     head, tail, nxt_tail, lane_cnt;
   logic                  lanes_ok;
   logic [`LDQ_PTR_W:0]   tail_sum, occ;

   // circular range [start_ptr, stop_ptr), empty when both are equal
   function automatic logic [`LDQ_DEPTH-1:0] range_mask(input ldq_pkg::ldq_ptr_t start_ptr,
                                                        input ldq_pkg::ldq_ptr_t stop_ptr);
      logic [`LDQ_DEPTH-1:0] m;
      int                    i;
      m = '0;
      for (i = 0; i < `LDQ_DEPTH; i++) begin
         if (start_ptr <= stop_ptr)
            m[i] = (i >= start_ptr) && (i < stop_ptr);
         else
            m[i] = (i >= start_ptr) || (i < stop_ptr);  // range wraps past the last slot
      end
      return m;
   endfunction

   // count valid lanes, they have to be packed from lane 0
   always_comb begin
      lane_cnt = '0;
      lanes_ok = 1'b1;
      for (int k = 0; k < `LDQ_LANES; k++) begin
         lane_cnt = lane_cnt + ldq_pkg::ldq_ptr_t'(i_alloc_vld[k]);
         if (k > 0 && i_alloc_vld[k] && !i_alloc_vld[k-1])
            lanes_ok = 1'b0;
      end
   end

   assign o_alloc_en = lanes_ok & ~i_flsh;

   always_comb begin
      tail_sum = {1'b0, tail} + (o_alloc_en ? {1'b0, lane_cnt} : '0);
      if (tail_sum >= DEPTH_W)
         tail_sum = tail_sum - DEPTH_W;  // wrap modulo depth
      nxt_tail = tail_sum[`LDQ_PTR_W-1:0];
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         head <= '0;
         tail <= '0;
      end else begin
         head <= i_cmmt_ptr;  // commit pointer is followed every cycle
         tail <= i_flsh ? i_flush_ptr : nxt_tail;
      end
   end

   assign o_commit_mask = range_mask(head, i_cmmt_ptr);
   assign o_flush_mask  = i_flsh ? range_mask(i_flush_ptr, tail) : '0;

   // occupancy, equal pointers mean full only when the head slot holds a load
   always_comb begin
      if (tail > head)
         occ = {1'b0, tail} - {1'b0, head};
      else if (tail < head)
         occ = {1'b0, tail} + DEPTH_W - {1'b0, head};
      else
         occ = i_head_vld ? DEPTH_W : '0;
   end

   assign o_stll = (occ > STALL_LVL);
   assign o_head = head;
   assign o_tail = tail;

endmodule

//--- hw/load_queue.sv
`timescale 1ns/10ps
`include "ldq_macros.svh"

module load_queue (
   input  logic                              clk,
   input  logic                              rst,
   // allocation from rename
   input  logic [`LDQ_LANES-1:0]             i_alloc_vld,
   input  logic [`LDQ_LANES*`LDQ_TAG_W-1:0]  i_alloc_tags,
   // address unit
   input  logic                              i_upd_vld,
   input  ldq_pkg::ldq_tag_t                 i_upd_tag,
   input  ldq_pkg::ldq_addr_t                i_upd_addr,
   input  ldq_pkg::ldq_preg_t                i_upd_preg,
   // commit and mispredict recovery
   input  ldq_pkg::ldq_ptr_t                 i_cmmt_ptr,
   input  logic                              i_flsh,
   input  ldq_pkg::ldq_ptr_t                 i_flush_ptr,
   // arbiter, cache and store queue
   input  logic                              i_ld_grnt,
   input  logic                              i_done,
   input  ldq_pkg::ldq_data_t                i_data_ca,
   input  logic                              i_fwd_rdy,
   input  logic                              i_fwd,
   input  ldq_pkg::ldq_data_t                i_data_sq,
   output logic                              o_ld_req,
   output ldq_pkg::ldq_addr_t                o_ld_addr,
   output ldq_pkg::ldq_preg_t                o_ld_preg,
   output ldq_pkg::ldq_tag_t                 o_ld_tag,
   output ldq_pkg::ldq_data_t                o_ld_data,
   output logic                              o_ld_wb,
   output logic                              o_stll
);

   ldq_pkg::ldq_ptr_t     head, tail, cur_ptr;
   logic [`LDQ_DEPTH-1:0] commit_mask, flush_mask, bid;
   logic                  alloc_en, head_vld, ld_rdy, busy, finish;

   ldq_ptr_ctrl u_ptr_ctrl (
      .clk           (clk),
      .rst           (rst),
      .i_alloc_vld   (i_alloc_vld),
      .i_flsh        (i_flsh),
      .i_flush_ptr   (i_flush_ptr),
      .i_cmmt_ptr    (i_cmmt_ptr),
      .i_head_vld    (head_vld),
      .o_head        (head),
      .o_tail        (tail),
      .o_alloc_en    (alloc_en),
      .o_commit_mask (commit_mask),
      .o_flush_mask  (flush_mask),
      .o_stll        (o_stll)
   );

   ldq_entry_array u_entry_array (
      .clk           (clk),
      .rst           (rst),
      .i_alloc_en    (alloc_en),
      .i_alloc_vld   (i_alloc_vld),
      .i_alloc_tags  (i_alloc_tags),
      .i_tail        (tail),
      .i_head        (head),
      .i_upd_vld     (i_upd_vld),
      .i_upd_tag     (i_upd_tag),
      .i_upd_addr    (i_upd_addr),
      .i_upd_preg    (i_upd_preg),
      .i_commit_mask (commit_mask),
      .i_flush_mask  (flush_mask),
      .i_cur_ptr     (cur_ptr),
      .i_finish      (finish),
      .i_busy        (busy),
      .o_bid         (bid),
      .o_head_vld    (head_vld),
      .o_cur_addr    (o_ld_addr),
      .o_cur_preg    (o_ld_preg),
      .o_cur_tag     (o_ld_tag)
   );

   ldq_oldest_select u_oldest_select (
      .clk       (clk),
      .rst       (rst),
      .i_bid     (bid),
      .i_head    (head),
      .i_busy    (busy),
      .o_cur_ptr (cur_ptr),
      .o_ld_rdy  (ld_rdy)
   );

   ldq_issue_ctrl u_issue_ctrl (
      .clk       (clk),
      .rst       (rst),
      .i_ld_rdy  (ld_rdy),
      .i_flsh    (i_flsh),
      .i_ld_grnt (i_ld_grnt),
      .i_done    (i_done),
      .i_data_ca (i_data_ca),
      .i_fwd_rdy (i_fwd_rdy),
      .i_fwd     (i_fwd),
      .i_data_sq (i_data_sq),
      .o_ld_req  (o_ld_req),
      .o_busy    (busy),
      .o_finish  (finish),
      .o_ld_wb   (o_ld_wb),
      .o_ld_data (o_ld_data)
   );

endmodule

//--- include/ldq_macros.svh
`ifndef LDQ_MACROS_SVH
`define LDQ_MACROS_SVH

// queue geometry
`define LDQ_DEPTH   24
`define LDQ_PTR_W   5

// entry field widths
`define LDQ_TAG_W   6
`define LDQ_PREG_W  6
`define LDQ_ADDR_W  16
`define LDQ_DATA_W  16

// loads the allocator may hand over per cycle
`define LDQ_LANES   4

`endif

//--- src.f
+incdir+include
hw/ldq_pkg.sv
hw/ldq_ptr_ctrl.sv
hw/ldq_entry_array.sv
hw/ldq_oldest_select.sv
hw/ldq_issue_ctrl.sv
hw/load_queue.sv
verif/tb_load_queue.sv

//--- verif/tb_load_queue.sv
`timescale 1ns/10ps
`include "ldq_macros.svh"

module tb_load_queue;

   localparam int CLK_PERIOD      = 4;
   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam int REQ_WAIT_MAX    = 20;
   localparam int STALL_LVL       = `LDQ_DEPTH - `LDQ_LANES;

   // order in which cache and store queue answer
   localparam int ORD_CA_FIRST  = 0;
   localparam int ORD_FWD_FIRST = 1;
   localparam int ORD_SAME      = 2;

   logic                             clk = 1'b0;
   logic                             rst;
   logic [`LDQ_LANES-1:0]            i_alloc_vld;
   logic [`LDQ_LANES*`LDQ_TAG_W-1:0] i_alloc_tags;
   logic                             i_upd_vld;
   ldq_pkg::ldq_tag_t                i_upd_tag;
   ldq_pkg::ldq_addr_t               i_upd_addr;
   ldq_pkg::ldq_preg_t               i_upd_preg;
   ldq_pkg::ldq_ptr_t                i_cmmt_ptr;
   logic                             i_flsh;
   ldq_pkg::ldq_ptr_t                i_flush_ptr;
   logic                             i_ld_grnt;
   logic                             i_done;
   ldq_pkg::ldq_data_t               i_data_ca;
   logic                             i_fwd_rdy;
   logic                             i_fwd;
   ldq_pkg::ldq_data_t               i_data_sq;
   logic                             o_ld_req;
   ldq_pkg::ldq_addr_t               o_ld_addr;
   ldq_pkg::ldq_preg_t               o_ld_preg;
   ldq_pkg::ldq_tag_t                o_ld_tag;
   ldq_pkg::ldq_data_t               o_ld_data;
   logic                             o_ld_wb;
   logic                             o_stll;

   int                 seed = 57125;
   int                 next_tag = 1;    // tags stay unique among live entries
   int                 tail_model = 0;
   int                 batch_tag;       // first load of the cache path batch
   ldq_pkg::ldq_addr_t exp_addr [2**`LDQ_TAG_W];
   ldq_pkg::ldq_preg_t exp_preg [2**`LDQ_TAG_W];

   load_queue u_load_queue (.*);

   always #(CLK_PERIOD/2) clk = ~clk;

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD + 16 * CLK_PERIOD);
      $display("simulation timed out before all tests finished");
      stop_run();
   end

   task automatic stop_run();
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         $display("** Error: %s got 0x%0h, expected 0x%0h", name, act, exp);
         stop_run();
      end
   endtask

   // lanes 0..n-1 valid for one cycle
   task automatic alloc_loads(input int n, output int first_tag);
      first_tag    = next_tag;
      i_alloc_vld  = '0;
      i_alloc_tags = '0;
      for (int k = 0; k < n; k++) begin
         i_alloc_vld[k] = 1'b1;
         i_alloc_tags[k*`LDQ_TAG_W +: `LDQ_TAG_W] = ldq_pkg::ldq_tag_t'(next_tag);
         next_tag++;
      end
      @(negedge clk);
      i_alloc_vld = '0;
      tail_model  = (tail_model + n) % `LDQ_DEPTH;
   endtask

   task automatic update_load(input int tag);
      exp_addr[tag] = $random(seed);
      exp_preg[tag] = $random(seed);
      i_upd_vld  = 1'b1;
      i_upd_tag  = ldq_pkg::ldq_tag_t'(tag);
      i_upd_addr = exp_addr[tag];
      i_upd_preg = exp_preg[tag];
      @(negedge clk);
      i_upd_vld = 1'b0;
   endtask

   task automatic wait_req();
      int n;
      n = 0;
      while (!o_ld_req) begin
         if (n == REQ_WAIT_MAX) begin
            $display("no load request seen within %0d cycles", n);
            stop_run();
         end
         @(negedge clk);
         n++;
      end
   endtask

   task automatic idle_check(input int cycles);
      repeat (cycles) begin
         check_val("o_ld_req", o_ld_req, 0);
         check_val("o_ld_wb", o_ld_wb, 0);
         @(negedge clk);
      end
   endtask

   // acts as arbiter, cache and store queue for one load
   task automatic serve_load(input int tag, input int order, input logic use_fwd);
      ldq_pkg::ldq_data_t ca_word;
      ldq_pkg::ldq_data_t sq_word;
      int                 cyc;
      ca_word = $random(seed);
      sq_word = $random(seed);
      wait_req();
      check_val("o_ld_addr", o_ld_addr, exp_addr[tag]);
      check_val("o_ld_tag", o_ld_tag, tag);
      i_ld_grnt = 1'b1;
      @(negedge clk);
      i_ld_grnt = 1'b0;
      check_val("o_ld_req", o_ld_req, 0);
      i_data_ca = ca_word;
      i_data_sq = sq_word;
      i_fwd     = use_fwd;
      if (order == ORD_SAME) begin
         i_done    = 1'b1;
         i_fwd_rdy = 1'b1;
      end else begin
         i_done    = (order == ORD_CA_FIRST);
         i_fwd_rdy = (order == ORD_FWD_FIRST);
         @(negedge clk);
         i_done    = ~i_done;     // the other side answers one cycle later
         i_fwd_rdy = ~i_fwd_rdy;
      end
      cyc = 0;
      do begin
         @(negedge clk);
         i_done    = 1'b0;
         i_fwd_rdy = 1'b0;
         cyc++;
      end while (!o_ld_wb && cyc < 8);
      check_val("o_ld_wb delay", cyc, (order == ORD_SAME) ? 2 : 1);
      check_val("o_ld_data", o_ld_data, use_fwd ? sq_word : ca_word);
      check_val("o_ld_tag", o_ld_tag, tag);
      check_val("o_ld_preg", o_ld_preg, exp_preg[tag]);
      @(negedge clk);
      check_val("o_ld_wb", o_ld_wb, 0);   // strobe is a single cycle
   endtask

   task automatic reset_values();
      check_val("o_ld_req", o_ld_req, 0);
      check_val("o_ld_wb", o_ld_wb, 0);
      check_val("o_stll", o_stll, 0);
      update_load(2**`LDQ_TAG_W - 1);     // tag never allocated
      idle_check(10);
   endtask

   task automatic cache_path();
      alloc_loads(4, batch_tag);
      update_load(batch_tag + 1);
      serve_load(batch_tag + 1, ORD_CA_FIRST, 1'b0);
   endtask

   task automatic forward_path();
      update_load(batch_tag + 2);
      serve_load(batch_tag + 2, ORD_SAME, 1'b1);
   endtask

   task automatic age_order();
      int first;
      alloc_loads(4, first);
      update_load(first);
      wait_req();
      check_val("o_ld_tag", o_ld_tag, first);
      // oldest is held without grant while the rest turn ready youngest first
      for (int k = 3; k >= 1; k--)
         update_load(first + k);
      for (int k = 0; k < 4; k++)
         serve_load(first + k, k % 3, (k % 2 == 1));
      idle_check(10);
   endtask

   task automatic flush_squash();
      int                first;
      int                c_tag;
      ldq_pkg::ldq_ptr_t fptr;
      fptr = ldq_pkg::ldq_ptr_t'((tail_model + 2) % `LDQ_DEPTH);
      alloc_loads(4, first);
      update_load(first + 2);
      update_load(first + 3);
      wait_req();
      check_val("o_ld_tag", o_ld_tag, first + 2);
      i_flsh      = 1'b1;
      i_flush_ptr = fptr;
      @(negedge clk);
      i_flsh     = 1'b0;
      tail_model = fptr;
      idle_check(10);
      update_load(first + 3);             // squashed so no entry matches
      idle_check(10);
      alloc_loads(2, c_tag);
      update_load(c_tag + 1);
      serve_load(c_tag + 1, ORD_FWD_FIRST, 1'b1);
   endtask

   task automatic commit_stall();
      int occ;
      int n;
      int first;
      occ = tail_model;                   // head still at slot 0
      check_val("o_stll", o_stll, occ > STALL_LVL);
      while (occ <= STALL_LVL) begin
         n = (STALL_LVL + 1 - occ >= `LDQ_LANES) ? `LDQ_LANES : STALL_LVL + 1 - occ;
         alloc_loads(n, first);
         occ += n;
         check_val("o_stll", o_stll, occ > STALL_LVL);
      end
      i_cmmt_ptr = 8;
      @(negedge clk);
      occ -= 8;
      check_val("o_stll", o_stll, occ > STALL_LVL);
      idle_check(5);
   endtask

   initial begin
      rst          = 1'b0;
      i_alloc_vld  = '0;
      i_alloc_tags = '0;
      i_upd_vld    = 1'b0;
      i_upd_tag    = '0;
      i_upd_addr   = '0;
      i_upd_preg   = '0;
      i_cmmt_ptr   = '0;
      i_flsh       = 1'b0;
      i_flush_ptr  = '0;
      i_ld_grnt    = 1'b0;
      i_done       = 1'b0;
      i_data_ca    = '0;
      i_fwd_rdy    = 1'b0;
      i_fwd        = 1'b0;
      i_data_sq    = '0;
      repeat (16) @(negedge clk);
      rst = 1'b1;
      @(negedge clk);

      reset_values();
      cache_path();
      forward_path();
      age_order();
      flush_squash();
      commit_stall();

      $display("Regression passed");
      $finish;
   end

endmodule
